// ==== axil_sub_pkg.sv ====
// shared address map, bus widths, response codes and address layout for the AXI4-Lite bridge.
package axil_sub_pkg;

    localparam int AXIL_ADDR_WIDTH = 32;
    localparam int AXIL_DATA_WIDTH = 32;

    // four 64 KiB windows follow the base address.
    localparam int SLAVE_NUM = 4;
    localparam logic [AXIL_ADDR_WIDTH-1:0] BASE_ADDR = 32'h43c0_0000;
    localparam int REGION_BITS = 14;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_CNT_WIDTH = 5;

    localparam logic [AXIL_DATA_WIDTH-1:0] ID_VALUE = 32'h5053_504c;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // the router looks at region and slot, the peripherals only at the offset.
    typedef union packed {
        logic [AXIL_ADDR_WIDTH-1:0] raw;
        struct packed {
            logic [REGION_BITS-1:0]                                      region;
            logic [$clog2(SLAVE_NUM)-1:0]                                slot;
            logic [AXIL_ADDR_WIDTH-REGION_BITS-$clog2(SLAVE_NUM)-1:0]    offset;
        } fields;
    } axil_addr_u;

endpackage

// ==== axil_req_if.sv ====
// single-request bus that links the AXI4-Lite front end, the router and the peripherals.
interface axil_req_if;

    logic                                       req_valid;
    logic                                       req_ready;
    logic                                       req_write;
    axil_sub_pkg::axil_addr_u                   req_addr;
    logic [axil_sub_pkg::AXIL_DATA_WIDTH-1:0]   req_wdata;
    logic [axil_sub_pkg::AXIL_DATA_WIDTH/8-1:0] req_wstrb;

    // one response pulse answers each accepted request.
    logic                                       rsp_valid;
    logic [axil_sub_pkg::AXIL_DATA_WIDTH-1:0]   rsp_data;
    logic [1:0]                                 rsp_resp;

    modport manager (
        output req_valid,
        output req_write,
        output req_addr,
        output req_wdata,
        output req_wstrb,
        input  req_ready,
        input  rsp_valid,
        input  rsp_data,
        input  rsp_resp
    );

    modport subordinate (
        input  req_valid,
        input  req_write,
        input  req_addr,
        input  req_wdata,
        input  req_wstrb,
        output req_ready,
        output rsp_valid,
        output rsp_data,
        output rsp_resp
    );

endinterface

// ==== axil_front.sv ====
// AXI4-Lite subordinate port that turns one bus transaction at a time into an internal request.
module axil_front (
    input  logic                                       clk_i,
    input  logic                                       rst_n_i,

    input  logic [axil_sub_pkg::AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr_i,
    input  logic                                       s_axil_awvalid_i,
    output logic                                       s_axil_awready_o,
    input  logic [axil_sub_pkg::AXIL_DATA_WIDTH-1:0]   s_axil_wdata_i,
    input  logic [axil_sub_pkg::AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb_i,
    input  logic                                       s_axil_wvalid_i,
    output logic                                       s_axil_wready_o,
    output logic [1:0]                                 s_axil_bresp_o,
    output logic                                       s_axil_bvalid_o,
    input  logic                                       s_axil_bready_i,
    input  logic [axil_sub_pkg::AXIL_ADDR_WIDTH-1:0]   s_axil_araddr_i,
    input  logic                                       s_axil_arvalid_i,
    output logic                                       s_axil_arready_o,
    output logic [axil_sub_pkg::AXIL_DATA_WIDTH-1:0]   s_axil_rdata_o,
    output logic [1:0]                                 s_axil_rresp_o,
    output logic                                       s_axil_rvalid_o,
    input  logic                                       s_axil_rready_i,

    axil_req_if.manager                                req_o
);

    logic [axil_sub_pkg::AXIL_ADDR_WIDTH-1:0]   aw_addr_q;
    logic [axil_sub_pkg::AXIL_ADDR_WIDTH-1:0]   ar_addr_q;
    logic [axil_sub_pkg::AXIL_DATA_WIDTH-1:0]   wdata_q;
    logic [axil_sub_pkg::AXIL_DATA_WIDTH/8-1:0] wstrb_q;
    logic [axil_sub_pkg::AXIL_DATA_WIDTH-1:0]   rdata_q;
    logic [1:0]                                 resp_q;
    logic aw_have_q, w_have_q, ar_have_q;
    logic issue_q, req_valid_q, req_write_q;
    logic bvalid_q, rvalid_q;
    logic idle, aw_hs, w_hs, ar_hs, wr_go, rd_go;

    // the state is IDLE, then ISSUE while the request is out, then RESP while B or R is held.
    // the ready outputs stay low while reset is held.
    assign idle = rst_n_i && !issue_q && !bvalid_q && !rvalid_q;

    assign s_axil_awready_o = idle && !aw_have_q;
    assign s_axil_wready_o  = idle && !w_have_q;
    assign s_axil_arready_o = idle && !ar_have_q;

    assign aw_hs = s_axil_awvalid_i && s_axil_awready_o;
    assign w_hs  = s_axil_wvalid_i && s_axil_wready_o;
    assign ar_hs = s_axil_arvalid_i && s_axil_arready_o;

    // a write that completes this cycle goes ahead of a pending read.
    assign wr_go = idle && (aw_have_q || aw_hs) && (w_have_q || w_hs);
    assign rd_go = idle && (ar_have_q || ar_hs) && !wr_go;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            aw_have_q   <= 1'b0;
            w_have_q    <= 1'b0;
            ar_have_q   <= 1'b0;
            issue_q     <= 1'b0;
            req_valid_q <= 1'b0;
            req_write_q <= 1'b0;
            bvalid_q    <= 1'b0;
            rvalid_q    <= 1'b0;
        end else begin
            aw_have_q <= !wr_go && (aw_have_q || aw_hs);
            w_have_q  <= !wr_go && (w_have_q || w_hs);
            ar_have_q <= !rd_go && (ar_have_q || ar_hs);
            if (wr_go || rd_go) begin
                issue_q     <= 1'b1;
                req_valid_q <= 1'b1;
                req_write_q <= wr_go;
            end else if (req_valid_q && req_o.req_ready) begin
                req_valid_q <= 1'b0;
            end
            if (issue_q && req_o.rsp_valid) begin
                issue_q  <= 1'b0;
                bvalid_q <= req_write_q;
                rvalid_q <= !req_write_q;
            end
            if (bvalid_q && s_axil_bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (rvalid_q && s_axil_rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_hs) begin
            aw_addr_q <= s_axil_awaddr_i;
        end
        if (w_hs) begin
            wdata_q <= s_axil_wdata_i;
            wstrb_q <= s_axil_wstrb_i;
        end
        if (ar_hs) begin
            ar_addr_q <= s_axil_araddr_i;
        end
        if (issue_q && req_o.rsp_valid) begin
            resp_q  <= req_o.rsp_resp;
            rdata_q <= req_o.rsp_data;
        end
    end

    assign req_o.req_valid    = req_valid_q;
    assign req_o.req_write    = req_write_q;
    assign req_o.req_addr.raw = req_write_q ? aw_addr_q : ar_addr_q;
    assign req_o.req_wdata    = wdata_q;
    assign req_o.req_wstrb    = wstrb_q;

    assign s_axil_bvalid_o = bvalid_q;
    assign s_axil_bresp_o  = resp_q;
    assign s_axil_rvalid_o = rvalid_q;
    assign s_axil_rresp_o  = resp_q;
    assign s_axil_rdata_o  = rdata_q;

    // only one response channel is ever busy.
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !(bvalid_q && rvalid_q));

endmodule

// ==== axil_router.sv ====
// window decoder that forwards each request to a peripheral or answers it with DECERR.
module axil_router (
    input logic              clk_i,
    input logic              rst_n_i,
    axil_req_if.subordinate  up_i,
    axil_req_if.manager      regs_o,
    axil_req_if.manager      strm_o
);

    logic region_hit, sel_regs, sel_strm, sel_err;
    logic err_q, regs_pend_q, strm_pend_q;

    assign region_hit = up_i.req_addr.fields.region ==
        axil_sub_pkg::BASE_ADDR[axil_sub_pkg::AXIL_ADDR_WIDTH-1 -: axil_sub_pkg::REGION_BITS];

    assign sel_regs = region_hit && (up_i.req_addr.fields.slot == 2'd0);
    assign sel_strm = region_hit && (up_i.req_addr.fields.slot == 2'd1);
    assign sel_err  = !sel_regs && !sel_strm;

    assign regs_o.req_valid = up_i.req_valid && sel_regs;
    assign regs_o.req_write = up_i.req_write;
    assign regs_o.req_addr  = up_i.req_addr;
    assign regs_o.req_wdata = up_i.req_wdata;
    assign regs_o.req_wstrb = up_i.req_wstrb;

    assign strm_o.req_valid = up_i.req_valid && sel_strm;
    assign strm_o.req_write = up_i.req_write;
    assign strm_o.req_addr  = up_i.req_addr;
    assign strm_o.req_wdata = up_i.req_wdata;
    assign strm_o.req_wstrb = up_i.req_wstrb;

    // unmapped windows are taken at once and answered by the router itself.
    assign up_i.req_ready = sel_regs ? regs_o.req_ready :
                            sel_strm ? strm_o.req_ready : 1'b1;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q       <= 1'b0;
            regs_pend_q <= 1'b0;
            strm_pend_q <= 1'b0;
        end else begin
            err_q       <= up_i.req_valid && sel_err;
            regs_pend_q <= (regs_o.req_valid && regs_o.req_ready) ||
                           (regs_pend_q && !regs_o.rsp_valid);
            strm_pend_q <= (strm_o.req_valid && strm_o.req_ready) ||
                           (strm_pend_q && !strm_o.rsp_valid);
        end
    end

    assign up_i.rsp_valid = regs_o.rsp_valid || strm_o.rsp_valid || err_q;

    always_comb begin
        up_i.rsp_data = '0;
        up_i.rsp_resp = axil_sub_pkg::RESP_DECERR;
        if (regs_o.rsp_valid) begin
            up_i.rsp_data = regs_o.rsp_data;
            up_i.rsp_resp = regs_o.rsp_resp;
        end else if (strm_o.rsp_valid) begin
            up_i.rsp_data = strm_o.rsp_data;
            up_i.rsp_resp = strm_o.rsp_resp;
        end
    end

    // a request and its pending response stay with one peripheral at a time.
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !((regs_o.req_valid || regs_pend_q) && (strm_o.req_valid || strm_pend_q)));

    // a peripheral answers only a request that was forwarded to it.
    assert property (@(posedge clk_i) disable iff (!rst_n_i) regs_o.rsp_valid |-> regs_pend_q);
    assert property (@(posedge clk_i) disable iff (!rst_n_i) strm_o.rsp_valid |-> strm_pend_q);

endmodule

// ==== axil_regfile.sv ====
// scratch register file with byte strobes and a read-only identification word in window 0.
module axil_regfile (
    input logic             clk_i,
    input logic             rst_n_i,
    axil_req_if.subordinate bus_i
);

    logic [axil_sub_pkg::AXIL_DATA_WIDTH-1:0] regs_q [4];
    logic [axil_sub_pkg::AXIL_DATA_WIDTH-1:0] rsp_data_q;
    logic [1:0]                               rsp_resp_q;
    logic                                     rsp_valid_q;
    logic [15:0]                              offset;
    logic [1:0]                               idx;
    logic                                     hit_reg, hit_id;

    assign offset  = bus_i.req_addr.fields.offset;
    assign idx     = offset[3:2];
    assign hit_reg = offset[15:4] == '0;
    assign hit_id  = offset[15:2] == 14'h4;

    // every access completes in one cycle.
    assign bus_i.req_ready = 1'b1;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            regs_q      <= '{default: '0};
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= bus_i.req_valid;
            if (bus_i.req_valid && bus_i.req_write && hit_reg) begin
                for (int b = 0; b < axil_sub_pkg::AXIL_DATA_WIDTH / 8; b++) begin
                    if (bus_i.req_wstrb[b]) begin
                        regs_q[idx][8*b +: 8] <= bus_i.req_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_i.req_valid) begin
            rsp_resp_q <= (hit_reg || hit_id) ? axil_sub_pkg::RESP_OKAY
                                              : axil_sub_pkg::RESP_SLVERR;
            if (bus_i.req_write || !(hit_reg || hit_id)) begin
                rsp_data_q <= '0;
            end else if (hit_reg) begin
                rsp_data_q <= regs_q[idx];
            end else begin
                rsp_data_q <= axil_sub_pkg::ID_VALUE;
            end
        end
    end

    assign bus_i.rsp_valid = rsp_valid_q;
    assign bus_i.rsp_data  = rsp_data_q;
    assign bus_i.rsp_resp  = rsp_resp_q;

endmodule

// ==== axil_stream_bridge.sv ====
// byte FIFOs between the stream registers of window 1 and the AXI-Stream ports.
module axil_stream_bridge (
    input  logic             clk_i,
    input  logic             rst_n_i,
    axil_req_if.subordinate  bus_i,
    output logic [7:0]       m_axis_tdata_o,
    output logic             m_axis_tvalid_o,
    input  logic             m_axis_tready_i,
    input  logic [7:0]       s_axis_tdata_i,
    input  logic             s_axis_tvalid_i,
    output logic             s_axis_tready_o
);

    // index 0 is the transmit FIFO and index 1 the receive FIFO.
    logic [7:0]                                       mem_q    [2][axil_sub_pkg::FIFO_DEPTH];
    logic [$clog2(axil_sub_pkg::FIFO_DEPTH)-1:0]      wr_ptr_q [2];
    logic [$clog2(axil_sub_pkg::FIFO_DEPTH)-1:0]      rd_ptr_q [2];
    logic [axil_sub_pkg::FIFO_CNT_WIDTH-1:0]          cnt_q    [2];
    logic [7:0]                                       din      [2];
    logic                                             push     [2];
    logic                                             pop      [2];
    logic [1:0]                                       full, empty;
    logic [axil_sub_pkg::AXIL_DATA_WIDTH-1:0]         rsp_data_q;
    logic [1:0]                                       rsp_resp_q;
    logic                                             rsp_valid_q;
    logic [15:0]                                      offset;
    logic                                             sel_data, sel_pop, sel_stat;

    assign offset   = bus_i.req_addr.fields.offset;
    assign sel_data = offset[15:2] == 14'd0;
    assign sel_pop  = offset[15:2] == 14'd1;
    assign sel_stat = offset[15:2] == 14'd2;

    // a write into a full transmit FIFO is dropped.
    assign push[0] = bus_i.req_valid && bus_i.req_write && sel_data && !full[0];
    assign din[0]  = bus_i.req_wdata[7:0];
    assign pop[0]  = m_axis_tvalid_o && m_axis_tready_i;
    assign push[1] = s_axis_tvalid_i && s_axis_tready_o;
    assign din[1]  = s_axis_tdata_i;
    assign pop[1]  = bus_i.req_valid && !bus_i.req_write && sel_pop && !empty[1];

    assign m_axis_tvalid_o = !empty[0];
    assign m_axis_tdata_o  = mem_q[0][rd_ptr_q[0]];
    assign s_axis_tready_o = !full[1];

    for (genvar f = 0; f < 2; f++) begin : g_fifo
        // the count equals FIFO_DEPTH exactly when its top bit is set.
        assign full[f]  = cnt_q[f][axil_sub_pkg::FIFO_CNT_WIDTH-1];
        assign empty[f] = cnt_q[f] == '0;

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                wr_ptr_q[f] <= '0;
                rd_ptr_q[f] <= '0;
                cnt_q[f]    <= '0;
            end else begin
                if (push[f]) begin
                    wr_ptr_q[f] <= wr_ptr_q[f] + 1'b1;
                end
                if (pop[f]) begin
                    rd_ptr_q[f] <= rd_ptr_q[f] + 1'b1;
                end
                if (push[f] && !pop[f]) begin
                    cnt_q[f] <= cnt_q[f] + 1'b1;
                end else if (pop[f] && !push[f]) begin
                    cnt_q[f] <= cnt_q[f] - 1'b1;
                end
            end
        end

        always_ff @(posedge clk_i) begin
            if (push[f]) begin
                mem_q[f][wr_ptr_q[f]] <= din[f];
            end
        end

        // a push into a full FIFO would carry the count past FIFO_DEPTH.
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            cnt_q[f] <= axil_sub_pkg::FIFO_DEPTH);
    end

    assign bus_i.req_ready = 1'b1;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= bus_i.req_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_i.req_valid) begin
            rsp_resp_q <= axil_sub_pkg::RESP_SLVERR;
            rsp_data_q <= '0;
            if (sel_data && bus_i.req_write) begin
                if (!full[0]) begin
                    rsp_resp_q <= axil_sub_pkg::RESP_OKAY;
                end
            end else if (sel_data) begin
                rsp_resp_q <= axil_sub_pkg::RESP_OKAY;
                rsp_data_q[0 +: axil_sub_pkg::FIFO_CNT_WIDTH] <= cnt_q[0];
            end else if (pop[1]) begin
                rsp_resp_q      <= axil_sub_pkg::RESP_OKAY;
                rsp_data_q[7:0] <= mem_q[1][rd_ptr_q[1]];
            end else if (sel_stat && !bus_i.req_write) begin
                rsp_resp_q <= axil_sub_pkg::RESP_OKAY;
                rsp_data_q[16 +: axil_sub_pkg::FIFO_CNT_WIDTH] <= cnt_q[1];
                rsp_data_q[0 +: axil_sub_pkg::FIFO_CNT_WIDTH]  <= cnt_q[0];
            end
        end
    end

    assign bus_i.rsp_valid = rsp_valid_q;
    assign bus_i.rsp_data  = rsp_data_q;
    assign bus_i.rsp_resp  = rsp_resp_q;

endmodule

// ==== axil_sub_top.sv ====
// top level of the bridge; the AXI4-Lite port and the two AXI-Stream ports as plain signals.
module axil_sub_top (
    input  logic                                       clk_i,
    input  logic                                       rst_n_i,

    input  logic [axil_sub_pkg::AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr_i,
    input  logic                                       s_axil_awvalid_i,
    output logic                                       s_axil_awready_o,
    input  logic [axil_sub_pkg::AXIL_DATA_WIDTH-1:0]   s_axil_wdata_i,
    input  logic [axil_sub_pkg::AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb_i,
    input  logic                                       s_axil_wvalid_i,
    output logic                                       s_axil_wready_o,
    output logic [1:0]                                 s_axil_bresp_o,
    output logic                                       s_axil_bvalid_o,
    input  logic                                       s_axil_bready_i,
    input  logic [axil_sub_pkg::AXIL_ADDR_WIDTH-1:0]   s_axil_araddr_i,
    input  logic                                       s_axil_arvalid_i,
    output logic                                       s_axil_arready_o,
    output logic [axil_sub_pkg::AXIL_DATA_WIDTH-1:0]   s_axil_rdata_o,
    output logic [1:0]                                 s_axil_rresp_o,
    output logic                                       s_axil_rvalid_o,
    input  logic                                       s_axil_rready_i,

    output logic [7:0]                                 m_axis_tdata_o,
    output logic                                       m_axis_tvalid_o,
    input  logic                                       m_axis_tready_i,
    input  logic [7:0]                                 s_axis_tdata_i,
    input  logic                                       s_axis_tvalid_i,
    output logic                                       s_axis_tready_o
);

    axil_req_if req_front ();
    axil_req_if req_regs ();
    axil_req_if req_strm ();

    // the front end shares every AXI4-Lite port name with the top level.
    axil_front i_axil_front (
        .req_o(req_front),
        .*
    );

    axil_router i_axil_router (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .up_i   (req_front),
        .regs_o (req_regs),
        .strm_o (req_strm)
    );

    axil_regfile i_axil_regfile (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .bus_i  (req_regs)
    );

    axil_stream_bridge i_axil_stream_bridge (
        .bus_i(req_strm),
        .*
    );

endmodule

// ==== tb_clk_gen.sv ====
// clock and reset source for the bridge testbench; 8 ns clock, reset low for ten cycles.
module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // reset is let go on a falling edge, away from the sampling edge.
    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== tb_axil_sub_top.sv ====
// directed testbench for the AXI4-Lite bridge; run it as the simulation top with the file list.
module tb_axil_sub_top;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk, rst_n;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0]  wstrb;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [1:0]  bresp, rresp;
    logic [7:0]  m_tdata, s_tdata;
    logic        m_tvalid, m_tready, s_tvalid, s_tready;
    int          errors;
    logic [31:0] lcg_state;
    string       test_name;

    tb_clk_gen clk_gen_i (.clk_o(clk), .rst_n_o(rst_n));

    axil_sub_top dut_i (
        .clk_i(clk), .rst_n_i(rst_n),
        .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
        .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
        .s_axil_wready_o(wready), .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid),
        .s_axil_bready_i(bready), .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid),
        .s_axil_arready_o(arready), .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp),
        .s_axil_rvalid_o(rvalid), .s_axil_rready_i(rready),
        .m_axis_tdata_o(m_tdata), .m_axis_tvalid_o(m_tvalid), .m_axis_tready_i(m_tready),
        .s_axis_tdata_i(s_tdata), .s_axis_tvalid_i(s_tvalid), .s_axis_tready_o(s_tready)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // each window spans 64 KiB above the base address.
    function automatic logic [31:0] win_addr(input int slot, input logic [15:0] offset);
        return axil_sub_pkg::BASE_ADDR + 32'(slot) * 32'h1_0000 + {16'h0, offset};
    endfunction

    function automatic logic sig_high(input int which);
        case (which)
            0: return awready;
            1: return wready;
            2: return arready;
            3: return bvalid;
            4: return rvalid;
            5: return m_tvalid;
            6: return s_tready;
            default: return rst_n;
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic abort_run(input string what);
        errors++;
        $display("%s: no %s within 100 cycles, giving up", test_name, what);
        $display("errors: %0d", errors);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // polled on falling edges, where every DUT output has settled.
    task automatic wait_high(input int which, input string what, output int waited);
        waited = 0;
        while (!sig_high(which) && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (!sig_high(which)) abort_run(what);
    endtask

    task automatic take_resp(input logic is_write, input int hold,
                             output logic [31:0] data, output logic [1:0] resp);
        int waited;
        int vsel;
        vsel = is_write ? 3 : 4;
        wait_high(vsel, is_write ? "bvalid" : "rvalid", waited);
        check("response latency", 3, waited + 1);
        data = is_write ? 32'h0 : rdata;
        resp = is_write ? bresp : rresp;
        repeat (hold) begin
            @(negedge clk);
            check("valid held", 1, sig_high(vsel));
            check("other channel idle", 0, sig_high(7 - vsel));
            check("front busy", 0, {awready, wready, arready});
            check("response stable", resp, is_write ? bresp : rresp);
            if (!is_write) check("read data stable", data, rdata);
        end
        bready = is_write;
        rready = !is_write;
        @(negedge clk);
        bready = 1'b0;
        rready = 1'b0;
        check("single response", 0, {bvalid, rvalid});
    endtask

    // order 0 sends AW and W together, 1 sends AW first, 2 sends W first.
    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int order, input int hold,
                              output logic [1:0] resp);
        int waited;
        logic [31:0] unused;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = (order != 2);
        wvalid  = (order != 1);
        wait_high(order == 2 ? 1 : 0, order == 2 ? "wready" : "awready", waited);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (order != 0) begin
            awvalid = (order == 2);
            wvalid  = (order == 1);
            wait_high(order == 2 ? 0 : 1, order == 2 ? "awready" : "wready", waited);
            @(negedge clk);
            awvalid = 1'b0;
            wvalid  = 1'b0;
        end
        take_resp(1'b1, hold, unused, resp);
    endtask

    task automatic axil_read(input logic [31:0] addr, input int hold,
                             output logic [31:0] data, output logic [1:0] resp);
        int waited;
        araddr  = addr;
        arvalid = 1'b1;
        wait_high(2, "arready", waited);
        @(negedge clk);
        arvalid = 1'b0;
        take_resp(1'b0, hold, data, resp);
    endtask

    task automatic regfile_access();
        logic [31:0] shadow [4];
        logic [31:0] wd, rd;
        logic [3:0]  strb;
        logic [1:0]  resp;
        test_name = "regfile";
        for (int i = 0; i < 4; i++) begin
            shadow[i] = next_random();
            axil_write(win_addr(0, 16'(4 * i)), shadow[i], 4'hf, 0, 0, resp);
            check("full write resp", axil_sub_pkg::RESP_OKAY, resp);
        end
        for (int i = 0; i < 4; i++) begin
            axil_read(win_addr(0, 16'(4 * i)), 0, rd, resp);
            check("full read data", shadow[i], rd);
            check("full read resp", axil_sub_pkg::RESP_OKAY, resp);
        end
        for (int i = 0; i < 4; i++) begin
            wd   = next_random();
            strb = 4'(next_random() >> 13);
            axil_write(win_addr(0, 16'(4 * i)), wd, strb, 0, 0, resp);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) shadow[i][8*b +: 8] = wd[8*b +: 8];
            end
            axil_read(win_addr(0, 16'(4 * i)), 0, rd, resp);
            check("strobed read data", shadow[i], rd);
        end
        axil_read(win_addr(0, 16'h10), 0, rd, resp);
        check("id word", axil_sub_pkg::ID_VALUE, rd);
        check("id resp", axil_sub_pkg::RESP_OKAY, resp);
        axil_write(win_addr(0, 16'h10), 32'hffff_ffff, 4'hf, 0, 0, resp);
        check("id write resp", axil_sub_pkg::RESP_OKAY, resp);
        axil_read(win_addr(0, 16'h10), 0, rd, resp);
        check("id after write", axil_sub_pkg::ID_VALUE, rd);
    endtask

    task automatic error_responses();
        logic [31:0] bad [4];
        logic [31:0] rd;
        logic [1:0]  resp;
        test_name = "errors";
        axil_read(win_addr(0, 16'h14), 0, rd, resp);
        check("unmapped read resp", axil_sub_pkg::RESP_SLVERR, resp);
        check("unmapped read data", 0, rd);
        axil_write(win_addr(0, 16'h40), 32'h1234_5678, 4'hf, 0, 0, resp);
        check("unmapped write resp", axil_sub_pkg::RESP_SLVERR, resp);
        // windows 2 and 3, the next region up, and an address far below the map.
        bad[0] = win_addr(2, 16'h0);
        bad[1] = win_addr(3, 16'h8);
        bad[2] = 32'h43c4_0000;
        bad[3] = 32'h0000_1000;
        foreach (bad[i]) begin
            axil_read(bad[i], 0, rd, resp);
            check("decode read resp", axil_sub_pkg::RESP_DECERR, resp);
            check("decode read data", 0, rd);
            axil_write(bad[i], next_random(), 4'hf, 0, 0, resp);
            check("decode write resp", axil_sub_pkg::RESP_DECERR, resp);
        end
    endtask

    task automatic tx_stream();
        logic [7:0]  sent [$];
        logic [31:0] wd, rd;
        logic [1:0]  resp;
        int          waited;
        test_name = "tx stream";
        m_tready = 1'b0;
        for (int i = 0; i < axil_sub_pkg::FIFO_DEPTH; i++) begin
            wd = next_random();
            sent.push_back(wd[7:0]);
            axil_write(win_addr(1, 16'h0), wd, 4'hf, 0, 0, resp);
            check("push resp", axil_sub_pkg::RESP_OKAY, resp);
        end
        axil_write(win_addr(1, 16'h0), next_random(), 4'hf, 0, 0, resp);
        check("push into full FIFO", axil_sub_pkg::RESP_SLVERR, resp);
        axil_read(win_addr(1, 16'h0), 0, rd, resp);
        check("tx count", axil_sub_pkg::FIFO_DEPTH, rd);
        axil_read(win_addr(1, 16'h8), 0, rd, resp);
        check("status word", axil_sub_pkg::FIFO_DEPTH, rd);
        m_tready = 1'b1;
        foreach (sent[i]) begin
            wait_high(5, "m_axis_tvalid", waited);
            check("stream byte", sent[i], m_tdata);
            @(negedge clk);
        end
        m_tready = 1'b0;
        check("tx drained", 0, m_tvalid);
    endtask

    task automatic rx_stream();
        logic [7:0]  sent [$];
        logic [31:0] wd, rd;
        logic [1:0]  resp;
        int          waited;
        test_name = "rx stream";
        for (int i = 0; i < axil_sub_pkg::FIFO_DEPTH; i++) begin
            wd       = next_random();
            s_tdata  = wd[7:0];
            s_tvalid = 1'b1;
            wait_high(6, "s_axis_tready", waited);
            sent.push_back(wd[7:0]);
            @(negedge clk);
        end
        s_tvalid = 1'b0;
        check("rx full", 0, s_tready);
        axil_read(win_addr(1, 16'h8), 0, rd, resp);
        check("rx count", 32'(axil_sub_pkg::FIFO_DEPTH) << 16, rd);
        foreach (sent[i]) begin
            axil_read(win_addr(1, 16'h4), 0, rd, resp);
            check("pop data", {24'h0, sent[i]}, rd);
            check("pop resp", axil_sub_pkg::RESP_OKAY, resp);
        end
        axil_read(win_addr(1, 16'h4), 0, rd, resp);
        check("pop from empty resp", axil_sub_pkg::RESP_SLVERR, resp);
        check("pop from empty data", 0, rd);
    endtask

    task automatic ordering_backpressure();
        logic [31:0] a, b, rd;
        logic [1:0]  resp;
        test_name = "ordering";
        a = next_random();
        b = next_random();
        axil_write(win_addr(0, 16'h8), a, 4'hf, 2, int'(next_random() & 32'h7), resp);
        check("w before aw resp", axil_sub_pkg::RESP_OKAY, resp);
        axil_write(win_addr(0, 16'hc), b, 4'hf, 1, int'(next_random() & 32'h7), resp);
        check("aw before w resp", axil_sub_pkg::RESP_OKAY, resp);
        axil_read(win_addr(0, 16'h8), int'(next_random() & 32'h7), rd, resp);
        check("held read data", a, rd);
        check("held read resp", axil_sub_pkg::RESP_OKAY, resp);
        axil_read(win_addr(0, 16'hc), int'(next_random() & 32'h7), rd, resp);
        check("held read data", b, rd);
        axil_write(win_addr(2, 16'h0), a, 4'hf, 2, int'(next_random() & 32'h7), resp);
        check("held decode resp", axil_sub_pkg::RESP_DECERR, resp);
        axil_read(win_addr(3, 16'h0), int'(next_random() & 32'h7), rd, resp);
        check("held decode resp", axil_sub_pkg::RESP_DECERR, resp);
        check("held decode data", 0, rd);
    endtask

    initial begin
        int waited;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        m_tready  = 1'b0;
        s_tdata   = '0;
        s_tvalid  = 1'b0;
        errors    = 0;
        lcg_state = 32'hca2d;
        test_name = "reset";
        @(negedge clk);
        check("outputs in reset", 0, {awready, wready, arready, bvalid, rvalid, m_tvalid});
        wait_high(7, "reset release", waited);
        regfile_access();
        error_responses();
        tx_stream();
        rx_stream();
        ordering_backpressure();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== axil_sub_top.f ====
axil_sub_pkg.sv
axil_req_if.sv
axil_front.sv
axil_router.sv
axil_regfile.sv
axil_stream_bridge.sv
axil_sub_top.sv
tb_clk_gen.sv
tb_axil_sub_top.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_axil_sub_top \
		-f axil_sub_top.f -o sim_axil_sub_top
	./obj_dir/sim_axil_sub_top | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
